// ==== flist.f ====
common/front_pkg.sv
common/line_req_if.sv
logic/line_arbiter.sv
fetch/fetch_unit.sv
fetch/inst_decode.sv
fetch/inst_queue.sv
logic/cpu_front.sv
verif/bmem_model.sv
verif/tb_cpu_front.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_cpu_front
RTL_TOP   ?= cpu_front
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_cpu_front.sv ====
`default_nettype none

module tb_cpu_front
    import front_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int total_insts     = 400;
    localparam int data_ops        = 8;
    localparam int lines_fetched   = total_insts / insts_per_line + 2;
    localparam int watchdog_cycles = 2 * (40 * lines_fetched + 40 * data_ops) + 8;
    localparam logic [xlen-1:0] data_base = 32'h8000_0000;

    logic                  clk;
    logic                  rst_n;
    logic [xlen-1:0]       bmem_addr;
    logic                  bmem_read;
    logic                  bmem_write;
    logic [bus_width-1:0]  bmem_wdata;
    logic                  bmem_ready;
    logic [xlen-1:0]       bmem_raddr;
    logic [bus_width-1:0]  bmem_rdata;
    logic                  bmem_rvalid;
    logic [xlen-1:0]       dmem_addr;
    logic                  dmem_read;
    logic                  dmem_write;
    logic [line_width-1:0] dmem_wdata;
    logic [line_width-1:0] dmem_rdata;
    logic                  dmem_resp;
    inst_info_t            out_inst [issue_width];
    logic [1:0]            out_count;
    logic                  out_pop;

    int              seed = 28;
    int              errors = 0;
    int              n_checked = 0;
    int              resp_count = 0;
    int              ops_issued = 0;
    logic [xlen-1:0] next_pc = reset_pc;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    cpu_front i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .bmem_ready (bmem_ready),
        .bmem_raddr (bmem_raddr),
        .bmem_rdata (bmem_rdata),
        .bmem_rvalid(bmem_rvalid),
        .dmem_addr  (dmem_addr),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .out_inst   (out_inst),
        .out_count  (out_count),
        .out_pop    (out_pop)
    );

    bmem_model i_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .bmem_ready (bmem_ready),
        .bmem_raddr (bmem_raddr),
        .bmem_rdata (bmem_rdata),
        .bmem_rvalid(bmem_rvalid)
    );

    // Expected instruction word at any PC
    function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] pc);
        logic [29:0] w;
        logic [6:0]  major;
        int          cls;
        w   = pc[31:2];
        cls = int'(w % 30'd9);
        case (cls)
            0:       major = 7'b0110111;
            1:       major = 7'b0010111;
            2:       major = 7'b1101111;
            3:       major = 7'b1100111;
            4:       major = 7'b1100011;
            5:       major = 7'b0000011;
            6:       major = 7'b0100011;
            7:       major = 7'b0010011;
            default: major = 7'b0110011;
        endcase
        return {w[24:18], w[14:10], w[9:5], w[17:15], w[4:0], major};
    endfunction

    // Class and register fields come straight from the word index
    function automatic inst_info_t expected_info(input logic [xlen-1:0] pc);
        inst_info_t  info;
        logic [29:0] w;
        w           = pc[31:2];
        info.pc     = pc;
        info.inst   = expected_word(pc);
        info.opcode = opcode_e'(4'(w % 30'd9));
        info.rd     = w[4:0];
        info.rs1    = w[9:5];
        info.rs2    = w[14:10];
        return info;
    endfunction

    function automatic logic [line_width-1:0] data_pattern(input logic [xlen-1:0] addr);
        logic [line_width-1:0] line;
        for (int k = 0; k < insts_per_line; k++) begin
            line[xlen*k +: xlen] = addr ^ (32'h5A5A_0000 + xlen'(k * 32'h0101));
        end
        return line;
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic data_write(input logic [xlen-1:0] addr, input logic [line_width-1:0] line);
        dmem_addr  <= addr;
        dmem_wdata <= line;
        dmem_write <= 1'b1;
        ops_issued++;
        do @(posedge clk); while (dmem_resp !== 1'b1);
        dmem_write <= 1'b0;
    endtask

    task automatic data_read(input logic [xlen-1:0] addr, output logic [line_width-1:0] line);
        dmem_addr <= addr;
        dmem_read <= 1'b1;
        ops_issued++;
        do @(posedge clk); while (dmem_resp !== 1'b1);
        line = dmem_rdata;
        dmem_read <= 1'b0;
    endtask

    // Every popped entry must continue the PC sequence
    always @(posedge clk) begin
        inst_info_t exp;
        if (rst_n && out_pop) begin
            for (int i = 0; i < int'(out_count); i++) begin
                exp = expected_info(next_pc);
                check_value("out_inst.pc", out_inst[i].pc, exp.pc);
                check_value("out_inst.inst", out_inst[i].inst, exp.inst);
                check_value("out_inst.opcode", 32'(out_inst[i].opcode), 32'(exp.opcode));
                check_value("out_inst.rd", 32'(out_inst[i].rd), 32'(exp.rd));
                check_value("out_inst.rs1", 32'(out_inst[i].rs1), 32'(exp.rs1));
                check_value("out_inst.rs2", 32'(out_inst[i].rs2), 32'(exp.rs2));
                next_pc = next_pc + 32'd4;
                n_checked++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && dmem_resp === 1'b1) begin
            resp_count++;
        end
    end

    // Pop in bursts with random idle gaps so the queue fills up
    initial begin
        int low_len;
        int high_len;
        wait (rst_n === 1'b1);
        @(posedge clk);
        while (n_checked < total_insts) begin
            low_len  = int'($unsigned($random(seed)) % 24);
            high_len = 1 + int'($unsigned($random(seed)) % 32);
            repeat (low_len) @(posedge clk);
            out_pop <= 1'b1;
            repeat (high_len) @(posedge clk);
            out_pop <= 1'b0;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles with %0d instructions checked",
                 watchdog_cycles, n_checked);
        $display("Data responses seen %0d of %0d issued", resp_count, ops_issued);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [line_width-1:0] got_line;
        logic [line_width-1:0] exp_line;
        logic [xlen-1:0]       addr;
        rst_n      = 1'b0;
        out_pop    = 1'b0;
        dmem_addr  = '0;
        dmem_read  = 1'b0;
        dmem_write = 1'b0;
        dmem_wdata = '0;
        repeat (8) @(posedge clk);
        check_value("bmem_read", 32'(bmem_read), 32'h0);
        check_value("bmem_write", 32'(bmem_write), 32'h0);
        check_value("dmem_resp", 32'(dmem_resp), 32'h0);
        check_value("out_count", 32'(out_count), 32'h0);
        rst_n <= 1'b1;

        // Write then read back, interleaved with ongoing fetch traffic
        for (int k = 0; k < data_ops / 2; k++) begin
            repeat (5 + 7 * k) @(posedge clk);
            addr     = data_base + xlen'(k * 32'h100);
            exp_line = data_pattern(addr);
            data_write(addr, exp_line);
            data_read(addr, got_line);
            for (int w = 0; w < insts_per_line; w++) begin
                check_value("dmem_rdata", got_line[xlen*w +: xlen], exp_line[xlen*w +: xlen]);
            end
        end

        wait (n_checked >= total_insts);
        repeat (4) @(posedge clk);
        check_value("dmem_resp count", 32'(resp_count), 32'(ops_issued));
        $display("Checked %0d instructions and %0d data operations, %0d errors",
                 n_checked, ops_issued, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/bmem_model.sv ====
`default_nettype none

// Burst memory behind the arbiter, with random stalls and fixed read latency
module bmem_model
    import front_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [xlen-1:0]      bmem_addr,
    input  logic                 bmem_read,
    input  logic                 bmem_write,
    input  logic [bus_width-1:0] bmem_wdata,
    output logic                 bmem_ready,
    output logic [xlen-1:0]      bmem_raddr,
    output logic [bus_width-1:0] bmem_rdata,
    output logic                 bmem_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int read_latency = 3;

    // Sparse storage, keyed by the byte address of each 64-bit beat
    logic [bus_width-1:0] mem [logic [xlen-1:0]];
    int                   seed = 28;
    int                   cycle;
    int                   wr_beat;
    int                   due_q [$];
    logic [xlen-1:0]      addr_q [$];
    logic [bus_width-1:0] data_q [$];

    // Unwritten words hold a valid instruction, class taken from the word index
    function automatic logic [xlen-1:0] fill_word(input logic [xlen-1:0] addr);
        logic [29:0] w;
        logic [6:0]  major;
        int          cls;
        w   = addr[31:2];
        cls = int'(w % 30'd9);
        case (cls)
            0:       major = 7'b0110111;
            1:       major = 7'b0010111;
            2:       major = 7'b1101111;
            3:       major = 7'b1100111;
            4:       major = 7'b1100011;
            5:       major = 7'b0000011;
            6:       major = 7'b0100011;
            7:       major = 7'b0010011;
            default: major = 7'b0110011;
        endcase
        return {w[24:18], w[14:10], w[9:5], w[17:15], w[4:0], major};
    endfunction

    function automatic logic [bus_width-1:0] read_beat(input logic [xlen-1:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {fill_word(addr + 32'd4), fill_word(addr)};
    endfunction

    initial begin
        bmem_ready  = 1'b0;
        bmem_raddr  = '0;
        bmem_rdata  = '0;
        bmem_rvalid = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            bmem_ready  <= 1'b0;
            bmem_rvalid <= 1'b0;
            cycle = 0;
            wr_beat = 0;
            due_q.delete();
            addr_q.delete();
            data_q.delete();
        end else begin
            cycle = cycle + 1;
            // Roughly three cycles in four are ready
            bmem_ready <= ($random(seed) % 4) != 0;
            if (bmem_read) begin
                for (int i = 0; i < beats_per_line; i++) begin
                    due_q.push_back(cycle + read_latency + i);
                    addr_q.push_back(bmem_addr);
                    data_q.push_back(read_beat(bmem_addr + xlen'(8 * i)));
                end
            end
            if (bmem_write && bmem_ready) begin
                mem[bmem_addr + xlen'(8 * wr_beat)] = bmem_wdata;
                wr_beat = (wr_beat + 1) % beats_per_line;
            end
            bmem_rvalid <= 1'b0;
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                void'(due_q.pop_front());
                bmem_rvalid <= 1'b1;
                bmem_raddr  <= addr_q.pop_front();
                bmem_rdata  <= data_q.pop_front();
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/cpu_front.sv ====
`default_nettype none

module cpu_front
    import front_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // Burst memory bus
    output logic [xlen-1:0]       bmem_addr,
    output logic                  bmem_read,
    output logic                  bmem_write,
    output logic [bus_width-1:0]  bmem_wdata,
    input  logic                  bmem_ready,
    input  logic [xlen-1:0]       bmem_raddr,
    input  logic [bus_width-1:0]  bmem_rdata,
    input  logic                  bmem_rvalid,

    // External line data port
    input  logic [xlen-1:0]       dmem_addr,
    input  logic                  dmem_read,
    input  logic                  dmem_write,
    input  logic [line_width-1:0] dmem_wdata,
    output logic [line_width-1:0] dmem_rdata,
    output logic                  dmem_resp,

    // Queue output
    output inst_info_t            out_inst [issue_width],
    output logic [1:0]            out_count,
    input  logic                  out_pop
);

    line_req_if fetch_bus ();
    line_req_if data_bus ();

    logic [xlen-1:0] pc;
    logic            push;
    logic            room;
    logic [xlen-1:0] line_words [insts_per_line];
    logic [xlen-1:0] line_pcs [insts_per_line];
    inst_info_t      decoded [insts_per_line];

    assign data_bus.addr  = dmem_addr;
    assign data_bus.read  = dmem_read;
    assign data_bus.write = dmem_write;
    assign data_bus.wdata = dmem_wdata;
    assign dmem_rdata     = data_bus.rdata;
    assign dmem_resp      = data_bus.resp;

    // Word i of the line sits at pc + 4*i
    always_comb begin
        for (int i = 0; i < insts_per_line; i++) begin
            line_words[i] = fetch_bus.rdata[xlen*i +: xlen];
            line_pcs[i]   = pc + xlen'(4 * i);
        end
    end

    fetch_unit i_fetch (
        .clk  (clk),
        .rst_n(rst_n),
        .mem  (fetch_bus.master),
        .room (room),
        .pc   (pc),
        .push (push)
    );

    for (genvar i = 0; i < insts_per_line; i++) begin : g_decode
        inst_decode i_decode (
            .pc  (line_pcs[i]),
            .inst(line_words[i]),
            .info(decoded[i])
        );
    end

    inst_queue i_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .in_line  (decoded),
        .pop      (out_pop),
        .room     (room),
        .out_inst (out_inst),
        .out_count(out_count)
    );

    line_arbiter i_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch      (fetch_bus.arbiter),
        .data       (data_bus.arbiter),
        .bmem_addr  (bmem_addr),
        .bmem_read  (bmem_read),
        .bmem_write (bmem_write),
        .bmem_wdata (bmem_wdata),
        .bmem_ready (bmem_ready),
        .bmem_rvalid(bmem_rvalid),
        .bmem_raddr (bmem_raddr),
        .bmem_rdata (bmem_rdata)
    );

endmodule

`default_nettype wire

// ==== fetch/inst_queue.sv ====
`default_nettype none

module inst_queue
    import front_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  inst_info_t in_line [insts_per_line],
    input  logic       pop,
    output logic       room,
    output inst_info_t out_inst [issue_width],
    output logic [1:0] out_count
);

    inst_info_t                entries [queue_depth];
    logic [queue_ptr_bits-1:0] head;
    logic [queue_ptr_bits-1:0] tail;
    logic [queue_cnt_bits-1:0] count;
    logic [queue_cnt_bits-1:0] pop_amount;
    logic [queue_cnt_bits-1:0] push_amount;

    // Room means a whole line still fits
    assign room = (count <= queue_cnt_bits'(queue_depth - insts_per_line));

    assign out_count   = (count >= queue_cnt_bits'(issue_width)) ? 2'(issue_width) : count[1:0];
    assign pop_amount  = pop ? queue_cnt_bits'(out_count) : '0;
    assign push_amount = push ? queue_cnt_bits'(insts_per_line) : '0;

    // Oldest entries first, pointer wraps naturally
    always_comb begin
        for (int i = 0; i < issue_width; i++) begin
            out_inst[i] = entries[head + queue_ptr_bits'(i)];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + pop_amount[queue_ptr_bits-1:0];
            count <= count + push_amount - pop_amount;
            if (push) begin
                tail <= tail + queue_ptr_bits'(insts_per_line);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < insts_per_line; i++) begin
                entries[tail + queue_ptr_bits'(i)] <= in_line[i];
            end
        end
    end

    a_push_with_room: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> room);

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= queue_cnt_bits'(queue_depth));

endmodule

`default_nettype wire

// ==== fetch/inst_decode.sv ====
`default_nettype none

module inst_decode
    import front_pkg::*;
(
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] inst,
    output inst_info_t      info
);

    opcode_e opcode;

    // Major opcode map, bits 6 to 0
    always_comb begin
        case (inst[6:0])
            7'b0110111: opcode = op_lui;
            7'b0010111: opcode = op_auipc;
            7'b1101111: opcode = op_jal;
            7'b1100111: opcode = op_jalr;
            7'b1100011: opcode = op_branch;
            7'b0000011: opcode = op_load;
            7'b0100011: opcode = op_store;
            7'b0010011: opcode = op_imm;
            7'b0110011: opcode = op_reg;
            default:    opcode = op_invalid;
        endcase
    end

    // Register fields sit at fixed positions for every format
    always_comb begin
        info.pc     = pc;
        info.inst   = inst;
        info.opcode = opcode;
        info.rd     = inst[11:7];
        info.rs1    = inst[19:15];
        info.rs2    = inst[24:20];
    end

endmodule

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
`default_nettype none

module fetch_unit
    import front_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    line_req_if.master      mem,
    input  logic            room,
    output logic [xlen-1:0] pc,
    output logic            push
);

    // High while a line read is outstanding
    logic pending;

    assign mem.addr  = pc;
    assign mem.read  = pending;
    assign mem.write = 1'b0;
    assign mem.wdata = '0;

    // Decoded line goes into the queue in the resp cycle
    assign push = pending && mem.resp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= reset_pc;
            pending <= 1'b0;
        end else begin
            if (push) begin
                pc      <= pc + xlen'(line_bytes);
                pending <= 1'b0;
            end else if (room && !pending) begin
                pending <= 1'b1;
            end
        end
    end

    a_resp_when_pending: assert property (@(posedge clk) disable iff (!rst_n)
        mem.resp |-> pending);

endmodule

`default_nettype wire

// ==== logic/line_arbiter.sv ====
`default_nettype none

module line_arbiter
    import front_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    line_req_if.arbiter          fetch,
    line_req_if.arbiter          data,
    output logic [xlen-1:0]      bmem_addr,
    output logic                 bmem_read,
    output logic                 bmem_write,
    output logic [bus_width-1:0] bmem_wdata,
    input  logic                 bmem_ready,
    input  logic                 bmem_rvalid,
    input  logic [xlen-1:0]      bmem_raddr,
    input  logic [bus_width-1:0] bmem_rdata
);

    arb_state_e            state;
    owner_e                owner;
    owner_e                grant_owner;
    owner_e                sel_owner;
    logic                  prefer_data;
    logic                  read_sent;
    logic [beat_bits-1:0]  beat;
    logic                  last_beat;
    logic                  fetch_resp_q;
    logic                  data_resp_q;
    logic                  fetch_req;
    logic                  data_req;
    logic                  grant_valid;
    logic                  sel_read;
    logic                  beat_hit;
    logic                  done;
    logic [line_width-1:0] sel_wdata;
    logic [line_width-1:0] line_q;

    // A request is still up during its own resp cycle, so ignore it there
    assign fetch_req   = (fetch.read || fetch.write) && !fetch_resp_q;
    assign data_req    = (data.read || data.write) && !data_resp_q;
    assign grant_valid = (state == arb_idle) && (fetch_req || data_req);
    assign grant_owner = (data_req && (prefer_data || !fetch_req)) ? own_data : own_fetch;
    assign sel_owner   = (state == arb_idle) ? grant_owner : owner;

    // Bus side follows the granted master
    assign bmem_addr  = (sel_owner == own_data) ? data.addr : fetch.addr;
    assign sel_read   = (sel_owner == own_data) ? data.read : fetch.read;
    assign sel_wdata  = (sel_owner == own_data) ? data.wdata : fetch.wdata;
    assign bmem_wdata = sel_wdata[beat*bus_width +: bus_width];
    assign bmem_write = (state == arb_write_burst);
    assign bmem_read  = bmem_ready &&
                        ((grant_valid && sel_read) || (state == arb_read_wait && !read_sent));

    assign last_beat = (beat == beat_bits'(beats_per_line - 1));
    assign beat_hit  = (state == arb_read_wait) && bmem_rvalid && (bmem_raddr == bmem_addr);
    assign done      = (beat_hit && last_beat) ||
                       (state == arb_write_burst && bmem_ready && last_beat);

    assign fetch.rdata = line_q;
    assign data.rdata  = line_q;
    assign fetch.resp  = fetch_resp_q;
    assign data.resp   = data_resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= arb_idle;
            owner        <= own_fetch;
            prefer_data  <= 1'b1;
            read_sent    <= 1'b0;
            beat         <= '0;
            fetch_resp_q <= 1'b0;
            data_resp_q  <= 1'b0;
        end else begin
            fetch_resp_q <= done && (owner == own_fetch);
            data_resp_q  <= done && (owner == own_data);
            case (state)
                arb_idle: begin
                    read_sent <= bmem_read;
                    if (grant_valid) begin
                        owner       <= grant_owner;
                        prefer_data <= (grant_owner == own_fetch);
                        beat        <= '0;
                        state       <= sel_read ? arb_read_wait : arb_write_burst;
                    end
                end
                arb_read_wait: begin
                    if (bmem_read) begin
                        read_sent <= 1'b1;
                    end
                    if (beat_hit) begin
                        beat <= beat + 1'b1;
                    end
                    if (done) begin
                        state <= arb_idle;
                    end
                end
                arb_write_burst: begin
                    // Ready low holds the current beat on the bus
                    if (bmem_ready) begin
                        beat <= beat + 1'b1;
                    end
                    if (done) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    // Collect read beats, lowest first
    always_ff @(posedge clk) begin
        if (beat_hit) begin
            line_q[beat*bus_width +: bus_width] <= bmem_rdata;
        end
    end

    a_read_single: assert property (@(posedge clk) disable iff (!rst_n)
        bmem_read |=> !bmem_read);

    a_rvalid_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        bmem_rvalid |-> state == arb_read_wait);

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch.resp || data.resp) |=> !(fetch.resp || data.resp));

endmodule

`default_nettype wire

// ==== common/line_req_if.sv ====
`default_nettype none

// One whole-line request channel between a master and the arbiter
interface line_req_if
    import front_pkg::*;
();

    logic [xlen-1:0]       addr;
    logic                  read;
    logic                  write;
    logic [line_width-1:0] wdata;
    logic [line_width-1:0] rdata;
    logic                  resp;

    modport master (
        output addr, read, write, wdata,
        input  rdata, resp
    );

    modport arbiter (
        input  addr, read, write, wdata,
        output rdata, resp
    );

endinterface

`default_nettype wire

// ==== common/front_pkg.sv ====
`default_nettype none

package front_pkg;

    // Datapath widths
    localparam int xlen           = 32;
    localparam int bus_width      = 64;
    localparam int line_width     = 256;
    localparam int beats_per_line = line_width / bus_width;
    localparam int insts_per_line = line_width / xlen;
    localparam int line_bytes     = line_width / 8;

    // Instruction queue sizing
    localparam int queue_depth = 16;
    localparam int issue_width = 2;

    localparam logic [xlen-1:0] reset_pc = 32'h1ECE_B000;

    // Derived counter and pointer widths
    localparam int beat_bits        = $clog2(beats_per_line);
    localparam int line_offset_bits = $clog2(line_bytes);
    localparam int queue_ptr_bits   = $clog2(queue_depth);
    localparam int queue_cnt_bits   = $clog2(queue_depth + 1);

    // Major opcode classes of RV32I
    typedef enum logic [3:0] {
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_imm,
        op_reg,
        op_invalid
    } opcode_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_read_wait,
        arb_write_burst
    } arb_state_e;

    typedef enum logic {
        own_fetch,
        own_data
    } owner_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        opcode_e         opcode;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
    } inst_info_t;

endpackage

`default_nettype wire
